// ==== src.f ====
+incdir+hw
hw/adc_ch_pkg.sv
hw/adc_pn_monitor.sv
hw/adc_ch_regs.sv
hw/adc_channel.sv
hw/adc_wb_slave.sv
hw/adc_ch_top.sv
bench/adc_ch_chk.sv
bench/adc_ch_tb.sv

// ==== bench/adc_ch_cases.txt ====
# columns: W addr data | R addr expect | O ch | D ch   (addr, data, expect in hex)
# S ch seq n flip   (decimal; seq 0 = PN9, 1 = PN23; flip 1 corrupts word n/2)

# reset values, global registers, unmapped reads
R 00 41440234
R 10 00000000
R 11 00000002
R 20 00000000
R 21 00000002
W 01 a5a55a5a
R 01 a5a55a5a
R 05 00000000
R 12 00000000
R 30 00000000
R ff 00000000

# data path on channel 0, enabled then disabled
W 10 00000001
R 10 00000001
D 0
D 0
W 10 00000000
R 10 00000000
D 0
D 1

# clean PN9 stream locks channel 0
S 0 0 40 0
R 11 00000000

# one flipped bit sets sticky err, oos stays clear
S 0 0 40 1
R 11 00000001
W 11 00000001
R 11 00000000

# PN23 stream on channel 1 while PN9 is selected
S 1 1 40 0
R 21 00000002

# select PN23, same stream locks
W 20 00000010
S 1 1 40 0
R 20 00000010
R 21 00000000

# over-range on channel 1 only
O 1
R 21 00000004
R 11 00000000
W 21 00000004
R 21 00000000

// ==== bench/adc_ch_tb.sv ====
/*
 * Two-channel ADC receive path testbench
 * runs the case file against the top level: bus accesses, PN streams,
 * over-range pulses and data path checks
 */

`timescale 1ns/100ps
`default_nettype none

`include "adc_ch_defs.svh"

module adc_ch_tb import adc_ch_pkg::*; ();

  localparam int          ACK_TIMEOUT = 20;
  localparam logic [63:0] FLIP_MASK   = 64'h1 << 40;
  localparam logic [15:0] LFSR_SEED   = 16'd63205;

  logic                          adc_clk;
  logic                          reset;
  logic                          wb_cyc;
  logic                          wb_stb;
  logic                          wb_we;
  logic [`ADC_CH_WB_ADDR_W-1:0]  wb_adr;
  logic [`ADC_CH_WB_DATA_W-1:0]  wb_dat_w;
  wire  [`ADC_CH_WB_DATA_W-1:0]  wb_dat_r;
  wire                           wb_ack;
  logic [`ADC_CH_DATA_W-1:0]     adc_data [0:`ADC_CH_NUM-1];
  logic                          adc_or [0:`ADC_CH_NUM-1];
  wire  [`ADC_CH_DATA_W-1:0]     adc_dfmt_data [0:`ADC_CH_NUM-1];
  wire                           adc_enable [0:`ADC_CH_NUM-1];

  // stream generator state per channel
  logic                          stream_on [0:`ADC_CH_NUM-1];
  pnseq_sel_e                    stream_seq [0:`ADC_CH_NUM-1];
  logic                          flip_req [0:`ADC_CH_NUM-1];
  logic [`ADC_CH_DATA_W-1:0]     stream_prev [0:`ADC_CH_NUM-1];
  logic [`ADC_CH_DATA_W-1:0]     hold_word [0:`ADC_CH_NUM-1];
  // enable bit as last written over the bus
  logic                          shadow_en [0:`ADC_CH_NUM-1];
  logic [15:0]                   lfsr_state;
  int                            check_errors;
  int                            timeout_errors;
  bit                            aborted;

  adc_ch_top u_adc_ch_top (
    .adc_clk         (adc_clk),
    .reset           (reset),
    .wb_cyc          (wb_cyc),
    .wb_stb          (wb_stb),
    .wb_we           (wb_we),
    .wb_adr          (wb_adr),
    .wb_dat_w        (wb_dat_w),
    .wb_dat_r        (wb_dat_r),
    .wb_ack          (wb_ack),
    .adc_data_0      (adc_data[0]),
    .adc_data_1      (adc_data[1]),
    .adc_or_0        (adc_or[0]),
    .adc_or_1        (adc_or[1]),
    .adc_dfmt_data_0 (adc_dfmt_data[0]),
    .adc_dfmt_data_1 (adc_dfmt_data[1]),
    .adc_enable_0    (adc_enable[0]),
    .adc_enable_1    (adc_enable[1])
  );

  // 8 ns clock
  always #4 adc_clk = ~adc_clk;

  // ******************************
  // reference models
  // ******************************

  // bit history oldest first where b[t] = b[t-9] ^ b[t-5] or b[t-23] ^ b[t-18]
  function automatic logic [63:0] pn_next(input logic [63:0] prev, input pnseq_sel_e sel);
    bit          hist [0:86];
    int          tap_a;
    int          tap_b;
    logic [63:0] word;
    tap_a = (sel == PNSEQ_PN23) ? 23 : 9;
    tap_b = (sel == PNSEQ_PN23) ? 18 : 5;
    for (int j = 0; j < 23; j++) begin
      hist[j] = prev[22-j];
    end
    for (int j = 23; j < 87; j++) begin
      hist[j] = hist[j-tap_a] ^ hist[j-tap_b];
    end
    for (int j = 0; j < 64; j++) begin
      word[63-j] = hist[23+j];
    end
    return word;
  endfunction

  // x^16+x^14+x^13+x^11+1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // free-running PN source or a held word while the stream is off
  always @(posedge adc_clk) begin
    logic [63:0] w;
    for (int k = 0; k < `ADC_CH_NUM; k++) begin
      if (stream_on[k]) begin
        w = pn_next(stream_prev[k], stream_seq[k]);
        stream_prev[k] <= w;
        adc_data[k]    <= flip_req[k] ? (w ^ FLIP_MASK) : w;
      end else begin
        adc_data[k] <= hold_word[k];
      end
    end
  end

  // ******************************
  // bus tasks
  // ******************************

  task bus_cycle(input logic [7:0] adr, input logic we, input logic [31:0] wdata,
                 output logic [31:0] rdata, output bit ok);
    int waited;
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    ok     = 1'b0;
    waited = 0;
    rdata  = '0;
    while (!ok && waited < ACK_TIMEOUT) begin
      @(posedge adc_clk);
      waited++;
      if (wb_ack) begin
        ok    = 1'b1;
        rdata = wb_dat_r;
      end
    end
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    // one edge with stb low lets the slave return to idle
    @(posedge adc_clk);
    if (!ok) begin
      $display("bus ack timeout at %0t, addr 0x%02h", $time, adr);
      timeout_errors++;
      aborted = 1'b1;
    end
  endtask

  task bus_write(input logic [7:0] adr, input logic [31:0] wdata);
    logic [31:0] rdata;
    bit          ok;
    bus_cycle(adr, 1'b1, wdata, rdata, ok);
    // track CTRL enable for the data path check
    for (int k = 0; k < `ADC_CH_NUM; k++) begin
      if (ok && adr[7:4] == (`ADC_CH_BASE >> 4) + k && adr[3:0] == `ADC_CH_REG_CTRL) begin
        shadow_en[k] = wdata[0];
      end
    end
  endtask

  task bus_read_check(input logic [7:0] adr, input logic [31:0] exp_data);
    logic [31:0] rdata;
    bit          ok;
    bus_cycle(adr, 1'b0, '0, rdata, ok);
    if (ok && rdata !== exp_data) begin
      $display("CHECK FAILED at %0t: read 0x%02h got 0x%08h, expected 0x%08h",
               $time, adr, rdata, exp_data);
      check_errors++;
    end
  endtask

  // ******************************
  // ADC side tasks
  // ******************************

  // n words with one bit of word n/2 flipped on request
  task run_stream(input int ch, input int seq, input int n, input int flip);
    stream_seq[ch] <= (seq == 1) ? PNSEQ_PN23 : PNSEQ_PN9;
    stream_on[ch]  <= 1'b1;
    for (int i = 1; i <= n; i++) begin
      @(posedge adc_clk);
      flip_req[ch] <= (flip != 0) && (i == n / 2);
    end
  endtask

  task pulse_or(input int ch);
    adc_or[ch] <= 1'b1;
    @(posedge adc_clk);
    adc_or[ch] <= 1'b0;
    @(posedge adc_clk);
  endtask

  task check_data_path(input int ch);
    logic [63:0] word;
    logic [63:0] exp_word;
    word = '0;
    for (int i = 0; i < 64; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      word       = {word[62:0], lfsr_state[0]};
    end
    stream_on[ch] <= 1'b0;
    hold_word[ch] <= word;
    // word reaches the input on the next edge and the output two edges later
    repeat (3) @(posedge adc_clk);
    exp_word = shadow_en[ch] ? word : '0;
    if (adc_enable[ch] !== shadow_en[ch]) begin
      $display("CHECK FAILED at %0t: ch %0d adc_enable %b, expected %b",
               $time, ch, adc_enable[ch], shadow_en[ch]);
      check_errors++;
    end
    if (adc_dfmt_data[ch] !== exp_word) begin
      $display("CHECK FAILED at %0t: ch %0d adc_dfmt_data 0x%016h, expected 0x%016h",
               $time, ch, adc_dfmt_data[ch], exp_word);
      check_errors++;
    end
  endtask

  // one line of the case file
  task run_line(input string line);
    string       cmd;
    int          cnt;
    logic [31:0] a0;
    logic [31:0] a1;
    int          ch;
    int          seq;
    int          n;
    int          flip;
    cnt = $sscanf(line, "%s", cmd);
    if (cnt < 1 || cmd.getc(0) == "#") begin
      return;
    end
    case (cmd)
      "W": begin
        void'($sscanf(line, "%s %h %h", cmd, a0, a1));
        bus_write(a0[7:0], a1);
      end
      "R": begin
        void'($sscanf(line, "%s %h %h", cmd, a0, a1));
        bus_read_check(a0[7:0], a1);
      end
      "S": begin
        void'($sscanf(line, "%s %d %d %d %d", cmd, ch, seq, n, flip));
        run_stream(ch, seq, n, flip);
      end
      "O": begin
        void'($sscanf(line, "%s %d", cmd, ch));
        pulse_or(ch);
      end
      "D": begin
        void'($sscanf(line, "%s %d", cmd, ch));
        check_data_path(ch);
      end
      default: begin
        $display("unknown command in case file: %s", cmd);
        check_errors++;
      end
    endcase
  endtask

  // ******************************
  // main sequence
  // ******************************

  initial begin
    int    fd;
    string line;
    int    assert_errors;
    adc_clk  = 1'b0;
    reset    = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    for (int k = 0; k < `ADC_CH_NUM; k++) begin
      adc_data[k]    = '0;
      adc_or[k]      = 1'b0;
      stream_on[k]   = 1'b0;
      stream_seq[k]  = PNSEQ_PN9;
      flip_req[k]    = 1'b0;
      stream_prev[k] = 64'h0123_4567_89ab_cdef;
      hold_word[k]   = '0;
      shadow_en[k]   = 1'b0;
    end
    lfsr_state     = LFSR_SEED;
    check_errors   = 0;
    timeout_errors = 0;
    aborted        = 1'b0;
    repeat (5) @(posedge adc_clk);
    reset <= 1'b0;
    @(posedge adc_clk);
    fd = $fopen("bench/adc_ch_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open case file bench/adc_ch_cases.txt");
      check_errors++;
    end else begin
      while (!aborted && $fgets(line, fd) != 0) begin
        run_line(line);
      end
      $fclose(fd);
    end
    repeat (4) @(posedge adc_clk);
    assert_errors = u_adc_ch_top.u_wb_slave.u_bus_chk.fail_cnt
                  + u_adc_ch_top.u_channel_0.u_pn_monitor.u_pn_chk.fail_cnt
                  + u_adc_ch_top.u_channel_1.u_pn_monitor.u_pn_chk.fail_cnt;
    $display("errors: check %0d, timeout %0d, assertion %0d",
             check_errors, timeout_errors, assert_errors);
    if (check_errors + timeout_errors + assert_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/adc_ch_chk.sv ====
/*
 * Bound checks
 * Wishbone ack handshake on the bus slave, lock flags on each PN monitor
 */

`timescale 1ns/100ps
`default_nettype none

module adc_ch_chk #(
  parameter bit BUS_SIDE = 1'b1
) (
  input wire clk,
  input wire reset,
  input wire wb_cyc,
  input wire wb_stb,
  input wire wb_ack,
  input wire pn_err,
  input wire pn_oos
);

  // failures so far, summed up by the testbench
  int fail_cnt = 0;

  if (BUS_SIDE) begin : g_bus
    // ack is a one-cycle pulse
    assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
      else begin
        $error("wb_ack high for more than one cycle");
        fail_cnt++;
      end
    // ack only follows a sampled request
    assert property (@(posedge clk) disable iff (reset) wb_ack |-> $past(wb_cyc && wb_stb))
      else begin
        $error("wb_ack without cyc and stb");
        fail_cnt++;
      end
  end else begin : g_pn
    // monitor leaves reset out of sync
    assert property (@(posedge clk) reset |=> pn_oos)
      else begin
        $error("pn_oos low right after reset");
        fail_cnt++;
      end
    // errors are only flagged while locked
    assert property (@(posedge clk) disable iff (reset) !(pn_err && pn_oos))
      else begin
        $error("pn_err high while out of sync");
        fail_cnt++;
      end
  end

endmodule

bind adc_wb_slave adc_ch_chk #(.BUS_SIDE(1'b1)) u_bus_chk (
  .clk    (adc_clk),
  .reset  (reset),
  .wb_cyc (wb_cyc),
  .wb_stb (wb_stb),
  .wb_ack (wb_ack),
  .pn_err (1'b0),
  .pn_oos (1'b1)
);

bind adc_pn_monitor adc_ch_chk #(.BUS_SIDE(1'b0)) u_pn_chk (
  .clk    (adc_clk),
  .reset  (reset),
  .wb_cyc (1'b0),
  .wb_stb (1'b0),
  .wb_ack (1'b0),
  .pn_err (pn_err),
  .pn_oos (pn_oos)
);

`default_nettype wire

// ==== hw/adc_ch_top.sv ====
/*
 * Two-channel ADC receive path
 * Wishbone slave in front of two PN-checked data channels
 */

`timescale 1ns/100ps
`default_nettype none

`include "adc_ch_defs.svh"

module adc_ch_top (
  input  wire                          adc_clk,
  input  wire                          reset,
  input  wire                          wb_cyc,
  input  wire                          wb_stb,
  input  wire                          wb_we,
  input  wire  [`ADC_CH_WB_ADDR_W-1:0] wb_adr,
  input  wire  [`ADC_CH_WB_DATA_W-1:0] wb_dat_w,
  output wire  [`ADC_CH_WB_DATA_W-1:0] wb_dat_r,
  output wire                          wb_ack,
  input  wire  [`ADC_CH_DATA_W-1:0]    adc_data_0,
  input  wire  [`ADC_CH_DATA_W-1:0]    adc_data_1,
  input  wire                          adc_or_0,
  input  wire                          adc_or_1,
  output wire  [`ADC_CH_DATA_W-1:0]    adc_dfmt_data_0,
  output wire  [`ADC_CH_DATA_W-1:0]    adc_dfmt_data_1,
  output wire                          adc_enable_0,
  output wire                          adc_enable_1
);

  // register ports, one entry per channel
  wire [`ADC_CH_NUM-1:0]                        up_wreq;
  wire [`ADC_CH_NUM-1:0]                        up_rreq;
  wire [`ADC_CH_NUM-1:0][3:0]                   up_addr;
  wire [`ADC_CH_NUM-1:0][`ADC_CH_WB_DATA_W-1:0] up_wdata;
  wire [`ADC_CH_NUM-1:0][`ADC_CH_WB_DATA_W-1:0] up_rdata;

  adc_wb_slave u_wb_slave (
    .adc_clk  (adc_clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .up_wreq  (up_wreq),
    .up_rreq  (up_rreq),
    .up_addr  (up_addr),
    .up_wdata (up_wdata),
    .up_rdata (up_rdata)
  );

  // channel 0 at 0x10
  adc_channel u_channel_0 (
    .adc_clk       (adc_clk),
    .reset         (reset),
    .adc_data      (adc_data_0),
    .adc_or        (adc_or_0),
    .adc_dfmt_data (adc_dfmt_data_0),
    .adc_enable    (adc_enable_0),
    .up_wreq       (up_wreq[0]),
    .up_rreq       (up_rreq[0]),
    .up_addr       (up_addr[0]),
    .up_wdata      (up_wdata[0]),
    .up_rdata      (up_rdata[0])
  );

  // channel 1 at 0x20
  adc_channel u_channel_1 (
    .adc_clk       (adc_clk),
    .reset         (reset),
    .adc_data      (adc_data_1),
    .adc_or        (adc_or_1),
    .adc_dfmt_data (adc_dfmt_data_1),
    .adc_enable    (adc_enable_1),
    .up_wreq       (up_wreq[1]),
    .up_rreq       (up_rreq[1]),
    .up_addr       (up_addr[1]),
    .up_wdata      (up_wdata[1]),
    .up_rdata      (up_rdata[1])
  );

endmodule

`default_nettype wire

// ==== hw/adc_wb_slave.sv ====
/*
 * Wishbone classic slave
 * decodes global and channel addresses, holds ID and scratch
 * and drives the per-channel register ports
 */

`timescale 1ns/100ps
`default_nettype none

`include "adc_ch_defs.svh"

module adc_wb_slave import adc_ch_pkg::*; (
  input  wire                                           adc_clk,
  input  wire                                           reset,
  input  wire                                           wb_cyc,
  input  wire                                           wb_stb,
  input  wire                                           wb_we,
  input  wire  [`ADC_CH_WB_ADDR_W-1:0]                  wb_adr,
  input  wire  [`ADC_CH_WB_DATA_W-1:0]                  wb_dat_w,
  output logic [`ADC_CH_WB_DATA_W-1:0]                  wb_dat_r,
  output logic                                          wb_ack,
  output logic [`ADC_CH_NUM-1:0]                        up_wreq,
  output logic [`ADC_CH_NUM-1:0]                        up_rreq,
  output logic [`ADC_CH_NUM-1:0][3:0]                   up_addr,
  output logic [`ADC_CH_NUM-1:0][`ADC_CH_WB_DATA_W-1:0] up_wdata,
  input  wire  [`ADC_CH_NUM-1:0][`ADC_CH_WB_DATA_W-1:0] up_rdata
);

  // channel select field above the 4-bit local offset
  localparam int SEL_W = `ADC_CH_WB_ADDR_W - 4;

  wb_state_e                    state;
  logic                         req;
  logic [`ADC_CH_NUM-1:0]       ch_hit;
  logic [`ADC_CH_WB_DATA_W-1:0] scratch;
  logic [`ADC_CH_WB_DATA_W-1:0] rd_mux;

  // request is taken only from idle
  assign req = (state == WB_IDLE) && wb_cyc && wb_stb;

  // ******************************
  // decode and channel ports
  // ******************************

  always_comb begin
    for (int k = 0; k < `ADC_CH_NUM; k++) begin
      ch_hit[k]   = (wb_adr[`ADC_CH_WB_ADDR_W-1:4] == SEL_W'((`ADC_CH_BASE >> 4) + k));
      up_wreq[k]  = req && wb_we && ch_hit[k];
      up_rreq[k]  = req && !wb_we && ch_hit[k];
      up_addr[k]  = wb_adr[3:0];
      up_wdata[k] = wb_dat_w;
    end
  end

  // unmapped addresses read zero
  always_comb begin
    rd_mux = '0;
    if (wb_adr == `ADC_CH_REG_ID) begin
      rd_mux = `ADC_CH_ID_VALUE;
    end else if (wb_adr == `ADC_CH_REG_SCRATCH) begin
      rd_mux = scratch;
    end
    for (int k = 0; k < `ADC_CH_NUM; k++) begin
      if (ch_hit[k]) begin
        rd_mux = up_rdata[k];
      end
    end
  end

  // ******************************
  // handshake
  // ******************************

  // ack for one cycle, then hold off until stb drops
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      state <= WB_IDLE;
    end else begin
      case (state)
        WB_IDLE:     if (req) state <= WB_ACK;
        WB_ACK:      state <= wb_stb ? WB_WAIT_END : WB_IDLE;
        WB_WAIT_END: if (!wb_stb) state <= WB_IDLE;
        default:     state <= WB_IDLE;
      endcase
    end
  end

  assign wb_ack = (state == WB_ACK);

  always_ff @(posedge adc_clk) begin
    if (reset) begin
      scratch <= '0;
    end else if (req && wb_we && (wb_adr == `ADC_CH_REG_SCRATCH)) begin
      scratch <= wb_dat_w;
    end
  end

  // read data is valid with ack
  always_ff @(posedge adc_clk) begin
    if (req && !wb_we) begin
      wb_dat_r <= rd_mux;
    end
  end

endmodule

`default_nettype wire

// ==== hw/adc_channel.sv ====
/*
 * ADC receive channel
 * PN monitor, register bank and the registered data output
 */

`timescale 1ns/100ps
`default_nettype none

`include "adc_ch_defs.svh"

module adc_channel import adc_ch_pkg::*; (
  input  wire                          adc_clk,
  input  wire                          reset,
  input  wire  [`ADC_CH_DATA_W-1:0]    adc_data,
  input  wire                          adc_or,
  output logic [`ADC_CH_DATA_W-1:0]    adc_dfmt_data,
  output wire                          adc_enable,
  input  wire                          up_wreq,
  input  wire                          up_rreq,
  input  wire  [3:0]                   up_addr,
  input  wire  [`ADC_CH_WB_DATA_W-1:0] up_wdata,
  output wire  [`ADC_CH_WB_DATA_W-1:0] up_rdata
);

  // monitor to register bank
  wire             pn_err;
  wire             pn_oos;
  wire pnseq_sel_e pnseq_sel;

  adc_pn_monitor u_pn_monitor (
    .adc_clk   (adc_clk),
    .reset     (reset),
    .adc_data  (adc_data),
    .pnseq_sel (pnseq_sel),
    .pn_err    (pn_err),
    .pn_oos    (pn_oos)
  );

  adc_ch_regs u_ch_regs (
    .adc_clk    (adc_clk),
    .reset      (reset),
    .up_wreq    (up_wreq),
    .up_rreq    (up_rreq),
    .up_addr    (up_addr),
    .up_wdata   (up_wdata),
    .up_rdata   (up_rdata),
    .adc_enable (adc_enable),
    .pnseq_sel  (pnseq_sel),
    .pn_err     (pn_err),
    .pn_oos     (pn_oos),
    .adc_or     (adc_or)
  );

  // output stage, one cycle late, zero while disabled
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      adc_dfmt_data <= '0;
    end else begin
      adc_dfmt_data <= adc_enable ? adc_data : '0;
    end
  end

endmodule

`default_nettype wire

// ==== hw/adc_ch_regs.sv ====
/*
 * ADC channel register bank
 * CTRL holds enable and sequence select, STATUS holds the sticky
 * PN error and over-range bits plus the live out-of-sync bit
 */

`timescale 1ns/100ps
`default_nettype none

`include "adc_ch_defs.svh"

module adc_ch_regs import adc_ch_pkg::*; (
  input  wire                          adc_clk,
  input  wire                          reset,
  input  wire                          up_wreq,
  input  wire                          up_rreq,
  input  wire  [3:0]                   up_addr,
  input  wire  [`ADC_CH_WB_DATA_W-1:0] up_wdata,
  output logic [`ADC_CH_WB_DATA_W-1:0] up_rdata,
  output logic                         adc_enable,
  output pnseq_sel_e                   pnseq_sel,
  input  wire                          pn_err,
  input  wire                          pn_oos,
  input  wire                          adc_or
);

  logic wr_ctrl;
  logic wr_status;
  logic clr_pn_err;
  logic clr_or;
  logic st_pn_err;
  logic st_or;

  // ******************************
  // write decode
  // ******************************

  assign wr_ctrl   = up_wreq && (up_addr == `ADC_CH_REG_CTRL);
  assign wr_status = up_wreq && (up_addr == `ADC_CH_REG_STATUS);

  // write one to clear
  assign clr_pn_err = wr_status && up_wdata[0];
  assign clr_or     = wr_status && up_wdata[2];

  // ******************************
  // control
  // ******************************

  // ctrl[0] enable, ctrl[7:4] sequence select
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      adc_enable <= 1'b0;
      pnseq_sel  <= PNSEQ_PN9;
    end else if (wr_ctrl) begin
      adc_enable <= up_wdata[0];
      pnseq_sel  <= pnseq_sel_e'(up_wdata[7:4]);
    end
  end

  // ******************************
  // status
  // ******************************

  // event is ored in after the clear
  // so a set in the clear cycle survives
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      st_pn_err <= 1'b0;
      st_or     <= 1'b0;
    end else begin
      st_pn_err <= (st_pn_err && !clr_pn_err) || pn_err;
      st_or     <= (st_or && !clr_or) || adc_or;
    end
  end

  // ******************************
  // read back
  // ******************************

  // combinational, the bus slave registers it with ack
  always_comb begin
    up_rdata = '0;
    if (up_rreq) begin
      case (up_addr)
        `ADC_CH_REG_CTRL: begin
          up_rdata[0]   = adc_enable;
          up_rdata[7:4] = pnseq_sel;
        end
        `ADC_CH_REG_STATUS: begin
          up_rdata[0] = st_pn_err;
          // oos is live, not sticky
          up_rdata[1] = pn_oos;
          up_rdata[2] = st_or;
        end
        default: begin
          up_rdata = '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/adc_pn_monitor.sv ====
/*
 * PN monitor
 * checks the ADC word stream against a self-seeded PN9 or PN23 sequence,
 * tracks lock and flags mismatching words while locked
 */

`timescale 1ns/100ps
`default_nettype none

`include "adc_ch_defs.svh"

module adc_pn_monitor import adc_ch_pkg::*; (
  input  wire                      adc_clk,
  input  wire                      reset,
  input  wire [`ADC_CH_DATA_W-1:0] adc_data,
  input  wire pnseq_sel_e          pnseq_sel,
  output logic                     pn_err,
  output logic                     pn_oos
);

  localparam int CNT_W = $clog2(`ADC_CH_PN_THRESH + 1);

  logic [`ADC_CH_DATA_W-1:0] data_in;
  logic [`ADC_CH_DATA_W-1:0] data_exp;
  logic                      pn_match;
  logic                      cnt_last;
  logic [CNT_W-1:0]          cnt;
  pn_state_e                 state;

  // next 64 sequence bits, msb first
  // lfsr[0] holds the most recent bit of the previous word
  function automatic logic [`ADC_CH_DATA_W-1:0] pn_word(
    input logic [`ADC_CH_DATA_W-1:0] prev,
    input pnseq_sel_e                sel
  );
    logic [22:0]               lfsr;
    logic                      fb;
    logic [`ADC_CH_DATA_W-1:0] word;
    lfsr = prev[22:0];
    word = '0;
    for (int i = `ADC_CH_DATA_W - 1; i >= 0; i--) begin
      // x^23+x^18+1 or x^9+x^5+1
      if (sel == PNSEQ_PN23) begin
        fb = lfsr[22] ^ lfsr[17];
      end else begin
        fb = lfsr[8] ^ lfsr[4];
      end
      word[i] = fb;
      lfsr    = {lfsr[21:0], fb};
    end
    return word;
  endfunction

  // ******************************
  // stage 1, data and expected word
  // ******************************

  // expected word is seeded from the word received just before
  always_ff @(posedge adc_clk) begin
    data_in  <= adc_data;
    data_exp <= pn_word(data_in, pnseq_sel);
  end

  // ******************************
  // stage 2, compare and lock
  // ******************************

  // an all-zero word would match a zero seed, never count it
  assign pn_match = (data_in == data_exp) && (data_in != '0);
  assign cnt_last = (cnt == CNT_W'(`ADC_CH_PN_THRESH - 1));

  // cnt holds the run of words pointing away from the current state
  always_ff @(posedge adc_clk) begin
    if (reset) begin
      state  <= PN_OOS;
      cnt    <= '0;
      pn_err <= 1'b0;
    end else begin
      pn_err <= 1'b0;
      case (state)
        PN_OOS: begin
          if (pn_match) begin
            if (cnt_last) begin
              state <= PN_LOCKED;
              cnt   <= '0;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end else begin
            cnt <= '0;
          end
        end
        PN_LOCKED: begin
          if (pn_match) begin
            cnt <= '0;
          end else if (cnt_last) begin
            // lock lost, this word is not reported as an error
            state <= PN_OOS;
            cnt   <= '0;
          end else begin
            cnt    <= cnt + 1'b1;
            pn_err <= 1'b1;
          end
        end
        default: begin
          state <= PN_OOS;
          cnt   <= '0;
        end
      endcase
    end
  end

  assign pn_oos = (state == PN_OOS);

endmodule

`default_nettype wire

// ==== hw/adc_ch_pkg.sv ====
/*
 * ADC channel shared types
 * PN sequence select, PN monitor state and bus slave state
 */

`default_nettype none

package adc_ch_pkg;

  // test sequence select, written through CTRL[7:4]
  // unknown codes fall back to pn9
  typedef enum logic [3:0] {
    PNSEQ_PN9  = 4'd0,
    PNSEQ_PN23 = 4'd1
  } pnseq_sel_e;

  // pn monitor lock state
  typedef enum logic {
    PN_OOS    = 1'b0,
    PN_LOCKED = 1'b1
  } pn_state_e;

  // wishbone handshake state
  typedef enum logic [1:0] {
    WB_IDLE     = 2'd0,
    WB_ACK      = 2'd1,
    WB_WAIT_END = 2'd2
  } wb_state_e;

endpackage

`default_nettype wire

// ==== hw/adc_ch_defs.svh ====
/*
 * ADC channel receive path constants
 * bus widths, register map, PN lock threshold and ID value
 */

`ifndef ADC_CH_DEFS_SVH
`define ADC_CH_DEFS_SVH

// data path widths
`define ADC_CH_DATA_W       64
`define ADC_CH_SAMPLE_W     16
`define ADC_CH_NUM          2

// wishbone bus
`define ADC_CH_WB_ADDR_W    8
`define ADC_CH_WB_DATA_W    32

// global register map (word addresses)
`define ADC_CH_REG_ID       8'h00
`define ADC_CH_REG_SCRATCH  8'h01
`define ADC_CH_BASE         8'h10

// channel-local offsets
`define ADC_CH_REG_CTRL     4'h0
`define ADC_CH_REG_STATUS   4'h1

// consecutive words needed to gain or lose lock
`define ADC_CH_PN_THRESH    16
`define ADC_CH_ID_VALUE     32'h4144_0234

`endif
